// File: verilog/isa_pkg.sv
package isa_pkg;

  //////////////////////////////////////////////////
  // Opcodes, one per top nibble of the word
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    add    = 4'h0,  // rd = rs + rt, saturating
    sub    = 4'h1,  // rd = rs - rt, saturating
    xor_op = 4'h2,  // Bitwise xor
    red    = 4'h3,  // Reduction add of nibbles
    sll    = 4'h4,  // Shift left logical by imm4
    sra    = 4'h5,  // Shift right arithmetic
    ror    = 4'h6,  // Rotate right
    paddsb = 4'h7,  // Parallel sub-word add
    lw     = 4'h8,  // Load word
    sw     = 4'h9,  // Store word
    llb    = 4'ha,  // Load low byte, imm8
    lhb    = 4'hb,  // Load high byte, imm8
    b      = 4'hc,  // Conditional PC-relative branch
    br     = 4'hd,  // Conditional register branch, resolved later
    pcs    = 4'he,  // rd = PC + 2
    hlt    = 4'hf   // Stop fetching
  } opcode_e;

  // Branch condition codes in bits 11:9
  typedef enum logic [2:0] {
    ne     = 3'b000,  // Z clear
    eq     = 3'b001,  // Z set
    gt     = 3'b010,  // Z and N clear
    lt     = 3'b011,  // N set
    gte    = 3'b100,
    lte    = 3'b101,
    ovf    = 3'b110,  // V set
    uncond = 3'b111   // Always
  } cond_e;

  //////////////////////////////////////////////////
  // Field positions
  //////////////////////////////////////////////////
  localparam int OPCODE_MSB = 15;
  localparam int OPCODE_LSB = 12;
  localparam int REG_WIDTH  = 4;   // Register specifier width
  localparam int RD_LSB     = 8;   // rd at 11:8
  localparam int RS_LSB     = 4;   // rs at 7:4
  localparam int RT_LSB     = 0;   // rt at 3:0
  localparam int COND_LSB   = 9;   // ccc at 11:9
  localparam int COND_WIDTH = 3;
  localparam int IMM_LSB    = 0;   // Both immediates sit at the bottom
  localparam int IMM9_WIDTH = 9;   // Branch offset, in words
  localparam int IMM8_WIDTH = 8;   // llb/lhb byte

  localparam int BRANCH_SHIFT = 1;  // Word offset to byte offset

endpackage

// File: verilog/pipe_pkg.sv
package pipe_pkg;

  //////////////////////////////////////////////////
  // Datapath and PC
  //////////////////////////////////////////////////
  localparam int WORD_WIDTH = 16;  // Instruction and address width

  localparam logic [WORD_WIDTH-1:0] RESET_PC = '0;  // First fetch address

  // Byte step between instructions, one word each
  localparam logic [WORD_WIDTH-1:0] PC_STEP = 16'd2;

  //////////////////////////////////////////////////
  // Instruction memory geometry
  //////////////////////////////////////////////////
  localparam int IMEM_WORDS      = 256;
  localparam int IMEM_ADDR_WIDTH = $clog2(IMEM_WORDS);  // 8

  // PC bit 0 is the byte select, so the word index starts at bit 1
  localparam int IMEM_ADDR_LSB = 1;

endpackage

// File: verilog/instr_mem.sv
module instr_mem (
  input  logic                                 clk,    // System clock
  input  logic [pipe_pkg::IMEM_ADDR_WIDTH-1:0] addr,   // Read word index
  output logic [pipe_pkg::WORD_WIDTH-1:0]      rdata,  // Word at addr, same cycle
  input  logic                                 we,     // Load strobe
  input  logic [pipe_pkg::IMEM_ADDR_WIDTH-1:0] waddr,  // Load word index
  input  logic [pipe_pkg::WORD_WIDTH-1:0]      wdata   // Load data
);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  // Plain flops, one word per entry
  // Contents are kept across reset so a program loaded
  // while reset is high is still there when it falls
  logic [pipe_pkg::WORD_WIDTH-1:0] mem [pipe_pkg::IMEM_WORDS];

  // Read side, purely combinational
  assign rdata = mem[addr];

  // Write side, takes effect on the edge
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // Loader must present a known index with every write
  a_waddr_known : assert property (
    @(posedge clk) we |-> !$isunknown(waddr)
  ) else $error("instr_mem: write with unknown address");

  // Loader data should be clean as well
  a_wdata_known : assert property (
    @(posedge clk) we |-> !$isunknown(wdata)
  ) else $error("instr_mem: write with unknown data");

endmodule

// File: verilog/fetch_stage.sv
module fetch_stage (
  input  logic                                 clk,            // System clock
  input  logic                                 reset,          // Sync, active high
  input  logic                                 stall,          // Hold from hazard logic
  input  logic                                 halt,           // hlt sitting in decode
  input  logic                                 branch_taken,   // Redirect from decode
  input  logic [pipe_pkg::WORD_WIDTH-1:0]      branch_target,  // Redirect address
  input  logic                                 imem_we,        // Program load strobe
  input  logic [pipe_pkg::IMEM_ADDR_WIDTH-1:0] imem_addr,      // Program load index
  input  logic [pipe_pkg::WORD_WIDTH-1:0]      imem_wdata,     // Program load word
  output logic [pipe_pkg::WORD_WIDTH-1:0]      if_instr,       // Word at current PC
  output logic [pipe_pkg::WORD_WIDTH-1:0]      if_pc_plus2     // Current PC + 2
);

  logic [pipe_pkg::WORD_WIDTH-1:0] pc;       // Current fetch address
  logic [pipe_pkg::WORD_WIDTH-1:0] pc_new;   // Address loaded on the next edge
  logic                            pc_wen;   // PC may advance this cycle

  //////////////////////////////////////////////////
  // Next PC
  //////////////////////////////////////////////////
  assign if_pc_plus2 = pc + pipe_pkg::PC_STEP;  // Sequential successor

  // Taken branch wins over fall-through
  assign pc_new = branch_taken ? branch_target : if_pc_plus2;

  // Stall and halt both freeze the front end
  assign pc_wen = !stall && !halt;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= pipe_pkg::RESET_PC;
    end else if (pc_wen) begin
      pc <= pc_new;
    end
  end

  //////////////////////////////////////////////////
  // Instruction memory
  //////////////////////////////////////////////////
  instr_mem imem0 (
    .clk   (clk),
    .addr  (pc[pipe_pkg::IMEM_ADDR_LSB +: pipe_pkg::IMEM_ADDR_WIDTH]),  // Word index
    .rdata (if_instr),
    .we    (imem_we),
    .waddr (imem_addr),
    .wdata (imem_wdata)
  );

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // Word aligned fetch, held over any sequence of updates
  a_pc_even : assert property (
    @(posedge clk) disable iff (reset) pc[0] == 1'b0
  ) else $error("fetch_stage: odd PC %h", pc);

  // Decode must never steer fetch to an odd address
  a_target_even : assert property (
    @(posedge clk) disable iff (reset) branch_taken |-> branch_target[0] == 1'b0
  ) else $error("fetch_stage: odd branch target %h", branch_target);

endmodule

// File: verilog/if_id_reg.sv
module if_id_reg (
  input  logic                            clk,          // System clock
  input  logic                            reset,        // Sync, active high
  input  logic                            stall,        // Hold everything
  input  logic                            halt,         // Hold everything, sticky
  input  logic                            flush,        // Drop the wrong-path word
  input  logic [pipe_pkg::WORD_WIDTH-1:0] if_instr,     // From fetch
  input  logic [pipe_pkg::WORD_WIDTH-1:0] if_pc_plus2,  // From fetch
  output logic                            id_valid,     // Buffer holds a real word
  output logic [pipe_pkg::WORD_WIDTH-1:0] id_instr,     // To decode
  output logic [pipe_pkg::WORD_WIDTH-1:0] id_pc_plus2   // To decode
);

  logic hold;  // No update this edge

  assign hold = stall || halt;

  //////////////////////////////////////////////////
  // Valid bit
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      id_valid <= 1'b0;            // Empty after reset
    end else if (!hold) begin
      id_valid <= !flush;          // Bubble on a taken branch
    end
  end

  //////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////
  // Loaded on flush too; valid low masks it
  always_ff @(posedge clk) begin
    if (!hold) begin
      id_instr    <= if_instr;
      id_pc_plus2 <= if_pc_plus2;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // Unblocked flush leaves exactly one bubble behind it
  a_flush_bubble : assert property (
    @(posedge clk) disable iff (reset)
      (flush && !stall && !halt) |=> !id_valid
  ) else $error("if_id_reg: valid word after flush");

endmodule

// File: verilog/decode_stage.sv
module decode_stage (
  input  logic                                 id_valid,       // Buffer word is real
  input  logic [pipe_pkg::WORD_WIDTH-1:0]      id_instr,       // Raw instruction
  input  logic [pipe_pkg::WORD_WIDTH-1:0]      id_pc_plus2,    // Its PC + 2
  input  logic                                 flag_z,         // Zero, from later stage
  input  logic                                 flag_v,         // Overflow
  input  logic                                 flag_n,         // Negative
  output logic                                 dec_valid,      // Decode outputs meaningful
  output isa_pkg::opcode_e                     dec_opcode,
  output logic [isa_pkg::REG_WIDTH-1:0]        dec_rd,
  output logic [isa_pkg::REG_WIDTH-1:0]        dec_rs,
  output logic [isa_pkg::REG_WIDTH-1:0]        dec_rt,
  output isa_pkg::cond_e                       dec_cond,
  output logic [isa_pkg::IMM8_WIDTH-1:0]       dec_imm8,
  output logic [pipe_pkg::WORD_WIDTH-1:0]      dec_pc_plus2,
  output logic                                 branch_taken,   // Redirect fetch, flush buffer
  output logic [pipe_pkg::WORD_WIDTH-1:0]      branch_target,  // PC + 2 + offset * 2
  output logic                                 halt            // hlt in decode
);

  localparam int EXT_WIDTH = pipe_pkg::WORD_WIDTH - isa_pkg::IMM9_WIDTH;  // Sign bits

  logic [isa_pkg::IMM9_WIDTH-1:0]  imm9;       // Raw branch offset, in words
  logic [pipe_pkg::WORD_WIDTH-1:0] imm9_sext;  // Sign extended
  logic [pipe_pkg::WORD_WIDTH-1:0] offset;     // Byte offset
  logic                            cond_true;  // Condition holds under flags

  //////////////////////////////////////////////////
  // Field split
  //////////////////////////////////////////////////
  assign dec_valid    = id_valid;
  assign dec_pc_plus2 = id_pc_plus2;

  assign dec_opcode = isa_pkg::opcode_e'(id_instr[isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB]);

  assign dec_rd = id_instr[isa_pkg::RD_LSB +: isa_pkg::REG_WIDTH];
  assign dec_rs = id_instr[isa_pkg::RS_LSB +: isa_pkg::REG_WIDTH];
  assign dec_rt = id_instr[isa_pkg::RT_LSB +: isa_pkg::REG_WIDTH];

  // Only meaningful for b and br
  assign dec_cond = isa_pkg::cond_e'(id_instr[isa_pkg::COND_LSB +: isa_pkg::COND_WIDTH]);

  assign dec_imm8 = id_instr[isa_pkg::IMM_LSB +: isa_pkg::IMM8_WIDTH];  // llb/lhb
  assign imm9     = id_instr[isa_pkg::IMM_LSB +: isa_pkg::IMM9_WIDTH];  // b only

  //////////////////////////////////////////////////
  // Condition evaluation
  //////////////////////////////////////////////////
  always_comb begin
    case (dec_cond)
      isa_pkg::ne:     cond_true = !flag_z;
      isa_pkg::eq:     cond_true = flag_z;
      isa_pkg::gt:     cond_true = !flag_z && !flag_n;
      isa_pkg::lt:     cond_true = flag_n;
      isa_pkg::gte:    cond_true = flag_z || (!flag_z && !flag_n);  // eq or gt
      isa_pkg::lte:    cond_true = flag_n || flag_z;                // lt or eq
      isa_pkg::ovf:    cond_true = flag_v;
      isa_pkg::uncond: cond_true = 1'b1;
      default:         cond_true = 1'b0;  // Unknown field, no redirect
    endcase
  end

  //////////////////////////////////////////////////
  // Branch target and redirect
  //////////////////////////////////////////////////
  assign imm9_sext = {{EXT_WIDTH{imm9[isa_pkg::IMM9_WIDTH-1]}}, imm9};
  assign offset    = imm9_sext << isa_pkg::BRANCH_SHIFT;  // Words to bytes

  // Relative to the following instruction
  assign branch_target = id_pc_plus2 + offset;

  // br is resolved further down, so it never redirects here
  assign branch_taken = id_valid && (dec_opcode == isa_pkg::b) && cond_true;

  // Stays high while hlt sits in the held buffer
  assign halt = id_valid && (dec_opcode == isa_pkg::hlt);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // No clock in this stage, so these run on every change
  always_comb begin
    a_taken_valid : assert (!branch_taken || dec_valid)
      else $error("decode_stage: branch taken on an empty slot");
    a_halt_branch : assert (!(halt && branch_taken))
      else $error("decode_stage: halt and branch together");
  end

endmodule

// File: verilog/cpu_front_end.sv
module cpu_front_end (
  input  logic                                 clk,           // System clock
  input  logic                                 reset,         // Sync, active high
  input  logic                                 stall,         // From hazard logic
  input  logic                                 flag_z,        // Condition flags
  input  logic                                 flag_v,
  input  logic                                 flag_n,
  input  logic                                 imem_we,       // Program load port
  input  logic [pipe_pkg::IMEM_ADDR_WIDTH-1:0] imem_addr,
  input  logic [pipe_pkg::WORD_WIDTH-1:0]      imem_wdata,
  output logic                                 dec_valid,     // Decoded instruction out
  output isa_pkg::opcode_e                     dec_opcode,
  output logic [isa_pkg::REG_WIDTH-1:0]        dec_rd,
  output logic [isa_pkg::REG_WIDTH-1:0]        dec_rs,
  output logic [isa_pkg::REG_WIDTH-1:0]        dec_rt,
  output isa_pkg::cond_e                       dec_cond,
  output logic [isa_pkg::IMM8_WIDTH-1:0]       dec_imm8,
  output logic [pipe_pkg::WORD_WIDTH-1:0]      dec_pc_plus2,
  output logic                                 branch_taken,  // Redirect this cycle
  output logic                                 halt           // Sticky until reset
);

  //////////////////////////////////////////////////
  // Stage to stage wires
  //////////////////////////////////////////////////
  logic [pipe_pkg::WORD_WIDTH-1:0] if_instr;       // Fetch -> buffer
  logic [pipe_pkg::WORD_WIDTH-1:0] if_pc_plus2;
  logic                            id_valid;       // Buffer -> decode
  logic [pipe_pkg::WORD_WIDTH-1:0] id_instr;
  logic [pipe_pkg::WORD_WIDTH-1:0] id_pc_plus2;
  logic [pipe_pkg::WORD_WIDTH-1:0] branch_target;  // Decode -> fetch

  // PC, adder and instruction memory
  fetch_stage fetch0 (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .halt          (halt),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .imem_we       (imem_we),
    .imem_addr     (imem_addr),
    .imem_wdata    (imem_wdata),
    .if_instr      (if_instr),
    .if_pc_plus2   (if_pc_plus2)
  );

  // Pipeline buffer; a taken branch squashes the word behind it
  if_id_reg ifid0 (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .halt        (halt),
    .flush       (branch_taken),
    .if_instr    (if_instr),
    .if_pc_plus2 (if_pc_plus2),
    .id_valid    (id_valid),
    .id_instr    (id_instr),
    .id_pc_plus2 (id_pc_plus2)
  );

  decode_stage decode0 (
    .id_valid      (id_valid),
    .id_instr      (id_instr),
    .id_pc_plus2   (id_pc_plus2),
    .flag_z        (flag_z),
    .flag_v        (flag_v),
    .flag_n        (flag_n),
    .dec_valid     (dec_valid),
    .dec_opcode    (dec_opcode),
    .dec_rd        (dec_rd),
    .dec_rs        (dec_rs),
    .dec_rt        (dec_rt),
    .dec_cond      (dec_cond),
    .dec_imm8      (dec_imm8),
    .dec_pc_plus2  (dec_pc_plus2),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .halt          (halt)
  );

endmodule

// File: verif/front_end_ref.svh
//////////////////////////////////////////////////
// Reference model of the front end
//////////////////////////////////////////////////
// Expects prog, prog_len, exp_pc2, exp_word and MAX_STEPS in the including module

// Opcode values in ISA table order
localparam logic [3:0] OP_B   = 4'hc;  // PC-relative branch
localparam logic [3:0] OP_BR  = 4'hd;  // Register branch, never redirects here
localparam logic [3:0] OP_HLT = 4'hf;

// Branch condition under constant flags
function automatic bit cond_holds(input logic [2:0] cond, input bit z, input bit v, input bit n);
  bit hit;
  case (cond)
    3'd0:    hit = !z;        // ne
    3'd1:    hit = z;         // eq
    3'd2:    hit = !z && !n;  // gt
    3'd3:    hit = n;         // lt
    3'd4:    hit = z || !n;   // gte, same as eq or gt
    3'd5:    hit = n || z;    // lte
    3'd6:    hit = v;         // ovf
    default: hit = 1'b1;      // uncond
  endcase
  return hit;
endfunction

// Follows the program from the reset PC and records every executed word
// Returns the stream length including the hlt, -1 when the path leaves
// the loaded words or runs past MAX_STEPS
function automatic int walk_program(input bit z, input bit v, input bit n);
  logic [15:0] pc;
  logic [15:0] word;
  int          widx;
  int          off;
  int          step;
  pc = pipe_pkg::RESET_PC;
  for (step = 0; step < MAX_STEPS; step++) begin
    widx = int'(pc[15:1]);  // Byte address to word index
    if (widx >= prog_len) return -1;
    word           = prog[widx];
    exp_pc2[step]  = pc + pipe_pkg::PC_STEP;
    exp_word[step] = word;
    if (word[15:12] == OP_HLT) return step + 1;
    if (word[15:12] == OP_B && cond_holds(word[11:9], z, v, n)) begin
      off = int'(signed'(word[8:0]));                  // Word offset, signed
      pc  = pc + pipe_pkg::PC_STEP + 16'(off * 2);     // From the next word
    end else begin
      pc = pc + pipe_pkg::PC_STEP;
    end
  end
  return -1;
endfunction

// File: verif/tb_front_end.sv
module tb_front_end;

  localparam int CLK_PERIOD    = 8;
  localparam int RESET_CYCLES  = 16;  // One program word loaded per reset cycle
  localparam int MAX_STEPS     = 64;
  localparam int HALT_HOLD     = 20;  // Cycles watched after halt
  localparam int WATCHDOG_TIME = 6 * MAX_STEPS * 8 * CLK_PERIOD;

  logic                                 clk;
  logic                                 reset;
  logic                                 stall;
  logic                                 flag_z;
  logic                                 flag_v;
  logic                                 flag_n;
  logic                                 imem_we;
  logic [pipe_pkg::IMEM_ADDR_WIDTH-1:0] imem_addr;
  logic [pipe_pkg::WORD_WIDTH-1:0]      imem_wdata;
  logic                                 dec_valid;
  isa_pkg::opcode_e                     dec_opcode;
  logic [3:0]                           dec_rd;
  logic [3:0]                           dec_rs;
  logic [3:0]                           dec_rt;
  isa_pkg::cond_e                       dec_cond;
  logic [7:0]                           dec_imm8;
  logic [15:0]                          dec_pc_plus2;
  logic                                 branch_taken;
  logic                                 halt;

  logic [3:0]  act_op;      // Opcode as raw bits
  logic [22:0] act_fields;  // rd, rs, rt, cond, imm8 side by side
  assign act_op     = dec_opcode;
  assign act_fields = {dec_rd, dec_rs, dec_rt, dec_cond, dec_imm8};

  logic [15:0] prog [RESET_CYCLES];    // Program image for the next load
  int          prog_len;
  logic [15:0] exp_pc2 [MAX_STEPS];    // Expected stream from the walker
  logic [15:0] exp_word [MAX_STEPS];
  int          exp_count;
  logic [15:0] saved_prog [4][RESET_CYCLES];  // Random programs, reused with stall
  logic [2:0]  saved_flags [4];
  bit          checking = 1'b0;        // Comparison armed
  int          idx = 0;                // Next expected entry
  bit          done = 1'b0;            // Stream finished for this run
  int          cmp_errs = 0;
  int          drv_errs = 0;
  int          err_base;
  int          n_pass = 0;
  int          n_fail = 0;
  string       test_name;

  `include "front_end_ref.svh"

  cpu_front_end dut0 (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired in test %s before the run finished", test_name);
    $display("STATUS: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // Comparison process
  //////////////////////////////////////////////////
  task automatic check_decode(input int i);
    logic [15:0] w;
    bit          taken;
    w     = exp_word[i];
    taken = (w[15:12] == OP_B) && cond_holds(w[11:9], flag_z, flag_v, flag_n);
    if (dec_pc_plus2 !== exp_pc2[i]) begin
      $display("MISMATCH %s decode %0d pc_plus2: expected %h actual %h",
               test_name, i, exp_pc2[i], dec_pc_plus2);
      cmp_errs++;
    end
    if (act_op !== w[15:12]) begin
      $display("MISMATCH %s decode %0d opcode: expected %h actual %h",
               test_name, i, w[15:12], act_op);
      cmp_errs++;
    end
    if (act_fields !== {w[11:0], w[11:9], w[7:0]}) begin
      $display("MISMATCH %s decode %0d fields: expected %h actual %h",
               test_name, i, {w[11:0], w[11:9], w[7:0]}, act_fields);
      cmp_errs++;
    end
    if (branch_taken !== taken) begin
      $display("MISMATCH %s decode %0d branch_taken: expected %b actual %b",
               test_name, i, taken, branch_taken);
      cmp_errs++;
    end
  endtask

  // Counts a decode on dec_valid high and stall low, up to the hlt
  always @(posedge clk) begin
    if (!checking) begin
      idx  = 0;
      done = 1'b0;
    end else if (!done && dec_valid && !stall) begin
      check_decode(idx);
      if (halt && idx + 1 < exp_count) begin
        $display("ERROR %s: halt after %0d of %0d expected decodes",
                 test_name, idx + 1, exp_count);
        cmp_errs++;
        done = 1'b1;
      end else if (idx + 1 == exp_count) begin
        if (!halt) begin
          $display("ERROR %s: expected stream ended without a halt", test_name);
          cmp_errs++;
        end
        done = 1'b1;
      end
      idx++;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus, all on the falling edge
  //////////////////////////////////////////////////
  task automatic load_program();
    int k;
    checking = 1'b0;
    reset    = 1'b1;
    stall    = 1'b0;
    for (k = 0; k < RESET_CYCLES; k++) begin
      imem_we    = (k < prog_len);
      imem_addr  = 8'(k);
      imem_wdata = prog[k];
      @(negedge clk);
    end
    imem_we  = 1'b0;
    reset    = 1'b0;
    checking = 1'b1;
  endtask

  task automatic wait_decodes(input int limit, input bit stall_en);
    while (!done && idx < limit) begin
      @(negedge clk);
      stall = stall_en && ($urandom_range(0, 99) < 30);  // About 30 percent
    end
    stall = 1'b0;
  endtask

  // Optional reset once cut decodes have been counted
  task automatic run_program(input bit stall_en, input int cut);
    exp_count = walk_program(flag_z, flag_v, flag_n);
    if (exp_count < 1) begin
      $display("ERROR %s: reference walk never reaches a hlt", test_name);
      drv_errs++;
      return;
    end
    load_program();
    if (cut > 0) begin
      wait_decodes(cut, stall_en);
      checking = 1'b0;
      reset    = 1'b1;
      @(negedge clk);
      if (dec_valid || branch_taken || halt) begin
        $display("ERROR %s: reset left dec_valid, branch_taken or halt high", test_name);
        drv_errs++;
      end
      load_program();
    end
    wait_decodes(MAX_STEPS + 1, stall_en);
  endtask

  task automatic check_halt_hold();
    int c;
    for (c = 0; c < HALT_HOLD; c++) begin
      @(negedge clk);
      if (!halt || !dec_valid || act_op !== OP_HLT
          || dec_pc_plus2 !== exp_pc2[exp_count - 1]) begin
        $display("ERROR %s: hlt did not stay in decode on cycle %0d", test_name, c);
        drv_errs++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Program builders
  //////////////////////////////////////////////////
  function automatic logic [15:0] filler_word();
    logic [3:0] op;
    op = 4'($urandom_range(0, 13));
    if (op >= OP_B) op = op + 4'd1;  // Skips b and hlt
    return {op, 12'($urandom)};
  endfunction

  // Four conditions, each b hops over one filler when taken
  task automatic make_cond(input int half);
    int i;
    for (i = 0; i < 4; i++) begin
      prog[2 * i]     = {OP_B, 3'(half * 4 + i), 9'd1};
      prog[2 * i + 1] = filler_word();
    end
    prog[8]  = {OP_HLT, 12'd0};
    prog_len = 9;
  endtask

  // Retries until the walk ends at a hlt with at least four decodes
  task automatic make_random(output bit ok);
    int         attempt;
    int         k;
    int         r;
    logic [8:0] off9;
    ok       = 1'b0;
    prog_len = RESET_CYCLES;
    for (attempt = 0; attempt < 500 && !ok; attempt++) begin
      {flag_z, flag_v, flag_n} = 3'($urandom);
      for (k = 0; k < RESET_CYCLES; k++) begin
        r    = $urandom_range(0, 99);
        off9 = 9'($urandom_range(0, 15)) - 9'd8;  // Back or forward by up to 8
        if (r < 30) prog[k] = {OP_B, 3'($urandom), off9};
        else if (r < 40) prog[k] = {OP_BR, 12'($urandom)};
        else if (r < 48) prog[k] = {OP_HLT, 12'd0};
        else prog[k] = filler_word();
      end
      ok = (walk_program(flag_z, flag_v, flag_n) >= 4);
    end
  endtask

  task automatic use_saved(input int p);
    int k;
    for (k = 0; k < RESET_CYCLES; k++) prog[k] = saved_prog[p][k];
    {flag_z, flag_v, flag_n} = saved_flags[p];
    prog_len = RESET_CYCLES;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_base  = cmp_errs + drv_errs;
  endtask

  task automatic end_test();
    int errs;
    errs = cmp_errs + drv_errs - err_base;
    if (errs == 0) n_pass++;
    else n_fail++;
    $display("test %s: %s, %0d errors", test_name, (errs == 0) ? "passed" : "failed", errs);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    int f;
    int h;
    int p;
    int k;
    bit ok;
    clk        = 1'b0;
    reset      = 1'b1;
    stall      = 1'b0;
    flag_z     = 1'b0;
    flag_v     = 1'b0;
    flag_n     = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    void'($urandom(82775));

    start_test("straight");
    for (k = 0; k < RESET_CYCLES - 1; k++) prog[k] = filler_word();
    prog[RESET_CYCLES - 1] = {OP_HLT, 12'($urandom)};
    prog_len = RESET_CYCLES;
    run_program(1'b0, 0);
    end_test();

    start_test("cond_table");
    for (f = 0; f < 8; f++) begin
      for (h = 0; h < 2; h++) begin
        {flag_z, flag_v, flag_n} = 3'(f);
        make_cond(h);
        run_program(1'b0, 0);
      end
    end
    end_test();

    start_test("random_branch");
    for (p = 0; p < 4; p++) begin
      make_random(ok);
      if (!ok) begin
        $display("ERROR %s: no terminating random program was found", test_name);
        drv_errs++;
      end
      for (k = 0; k < RESET_CYCLES; k++) saved_prog[p][k] = prog[k];
      saved_flags[p] = {flag_z, flag_v, flag_n};
      run_program(1'b0, 0);
    end
    end_test();

    start_test("random_stall");
    for (p = 0; p < 4; p++) begin
      use_saved(p);
      run_program(1'b1, 0);
    end
    end_test();

    start_test("halt_hold");
    use_saved(1);
    run_program(1'b0, 0);
    check_halt_hold();
    end_test();

    start_test("mid_reset");
    use_saved(2);
    run_program(1'b0, 3);
    end_test();

    $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+verif
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/instr_mem.sv
verilog/fetch_stage.sv
verilog/if_id_reg.sv
verilog/decode_stage.sv
verilog/cpu_front_end.sv
verif/tb_front_end.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_front_end -o sim_front_end
out=$(./obj_dir/sim_front_end)
echo "$out"
echo "$out" | grep -q "^STATUS: PASS$"
